// ==== hdl/memPkg.sv ====
`default_nettype none

package memPkg;

    localparam int addrWidth   = 32;
    localparam int dataWidth   = 32;
    localparam int ramAddrBits = 12;
    localparam int ramBytes    = 1 << ramAddrBits;
    localparam int wordBytes   = dataWidth / 8;

    typedef logic [addrWidth-1:0] memAddr;
    typedef logic [dataWidth-1:0] memWord;
    typedef logic [7:0]           memByte;

    // byte index within a transfer, up to wordBytes
    typedef logic [2:0] stageCount;

    localparam stageCount lastFetchStage = stageCount'(wordBytes);

    // bytes moved is 1 << size
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize;

    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } portOwner;

    typedef struct packed {
        logic      isStore;
        logic      isSigned;
        accessSize size;
        memAddr    addr;
        memWord    wdata;
    } memOp;

    typedef struct packed {
        logic      valid;
        logic      isStore;
        accessSize size;
        memAddr    addr;
        memWord    wdata;
    } dataReq;

endpackage

`default_nettype wire

// ==== hdl/byteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  wire                            clk,
    input  wire [memPkg::ramAddrBits-1:0]  addr,
    input  wire                            we,
    input  wire memPkg::memByte            wdata,
    output memPkg::memByte                 rdata
);

    memPkg::memByte mem [memPkg::ramBytes];

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/memCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                rdy,
    input  wire                                ioFull,
    input  wire                                fetchReq,
    input  wire memPkg::memAddr                fetchAddr,
    output logic                               fetchDone,
    output memPkg::memWord                     fetchWord,
    input  wire memPkg::dataReq                dataReq,
    output logic                               dataDone,
    output memPkg::memWord                     dataWord,
    output memPkg::portOwner                   owner,
    output logic [memPkg::ramAddrBits-1:0]     ramAddr,
    output logic                               ramWe,
    output memPkg::memByte                     ramWdata,
    input  wire memPkg::memByte                ramRdata
);

    memPkg::portOwner  ownerQ;
    memPkg::portOwner  active;
    memPkg::stageCount stage;
    memPkg::stageCount byteCount;
    memPkg::memAddr    baseAddr;
    memPkg::memAddr    byteAddr;
    memPkg::memWord    wordQ;
    memPkg::memWord    assembled;
    logic [1:0]        bytePrev;
    logic              hold;
    logic              fetchEnd;
    logic              dataEnd;

    assign hold  = !rdy || ioFull;
    assign owner = ownerQ;

    // new transfer picked only while idle, data first
    always_comb begin
        if (ownerQ != memPkg::ownerNone) begin
            active = ownerQ;
        end else if (dataReq.valid) begin
            active = memPkg::ownerData;
        end else if (fetchReq) begin
            active = memPkg::ownerFetch;
        end else begin
            active = memPkg::ownerNone;
        end
    end

    always_comb begin
        case (dataReq.size)
            memPkg::sizeByte: byteCount = 3'd1;
            memPkg::sizeHalf: byteCount = 3'd2;
            default:          byteCount = 3'd4;
        endcase
    end

    assign fetchEnd = (active == memPkg::ownerFetch) && (stage == memPkg::lastFetchStage);

    // stores end on their last byte, loads one cycle later when it comes back
    assign dataEnd = (active == memPkg::ownerData) &&
                     (stage == (dataReq.isStore ? byteCount - 3'd1 : byteCount));

    assign fetchDone = fetchEnd && !hold;
    assign dataDone  = dataEnd && !hold;

    assign baseAddr = (active == memPkg::ownerFetch) ? fetchAddr : dataReq.addr;
    // a held transfer reads its previous byte again so ramRdata stays valid
    assign byteAddr = baseAddr + memPkg::memAddr'(stage)
                      - memPkg::memAddr'(hold && (stage != 3'd0));
    assign ramAddr  = byteAddr[memPkg::ramAddrBits-1:0];
    assign ramWe    = !hold && (active == memPkg::ownerData) && dataReq.isStore;
    assign ramWdata = dataReq.wdata[{stage[1:0], 3'b000} +: 8];

    // wraps to 3 at stage 4
    assign bytePrev = stage[1:0] - 2'd1;

    // the byte addressed last cycle is on ramRdata now
    always_comb begin
        assembled = wordQ;
        if (stage != 3'd0) begin
            assembled[{bytePrev, 3'b000} +: 8] = ramRdata;
        end
    end

    assign fetchWord = assembled;
    assign dataWord  = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            ownerQ <= memPkg::ownerNone;
            stage  <= '0;
        end else if (!hold) begin
            if (fetchEnd || dataEnd) begin
                ownerQ <= memPkg::ownerNone;
                stage  <= '0;
            end else if (active != memPkg::ownerNone) begin
                ownerQ <= active;
                stage  <= stage + 3'd1;
            end
        end
    end

    // cleared at stage 0, so bytes above the access size read as zero
    always_ff @(posedge clk) begin
        if (!hold) begin
            if (stage == 3'd0) begin
                wordQ <= '0;
            end else begin
                wordQ <= assembled;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instFetch (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  fetchEnable,
    input  wire                  jumpValid,
    input  wire memPkg::memAddr  jumpTarget,
    output logic                 fetchReq,
    output memPkg::memAddr       fetchAddr,
    input  wire                  fetchDone,
    input  wire memPkg::memWord  fetchWord,
    output logic                 instValid,
    output memPkg::memWord       inst,
    output memPkg::memAddr       instPc
);

    memPkg::memAddr pc;
    memPkg::memAddr pendingPc;
    logic           jumpPending;

    assign fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            fetchReq    <= 1'b0;
            jumpPending <= 1'b0;
            instValid   <= 1'b0;
        end else begin
            instValid <= 1'b0;
            if (fetchReq) begin
                if (fetchDone) begin
                    fetchReq    <= 1'b0;
                    jumpPending <= 1'b0;
                    // word from the old path is dropped
                    if (jumpValid) begin
                        pc <= jumpTarget;
                    end else if (jumpPending) begin
                        pc <= pendingPc;
                    end else begin
                        instValid <= 1'b1;
                        pc        <= pc + memPkg::memAddr'(memPkg::wordBytes);
                    end
                end else if (jumpValid) begin
                    jumpPending <= 1'b1;
                end
            end else begin
                fetchReq <= fetchEnable;
                if (jumpValid) begin
                    pc <= jumpTarget;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            inst   <= fetchWord;
            instPc <= pc;
        end
        if (fetchReq && jumpValid) begin
            pendingPc <= jumpTarget;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  lsuStart,
    input  wire memPkg::memOp    lsuOp,
    output logic                 busy,
    output memPkg::dataReq       dataReq,
    input  wire                  dataDone,
    input  wire memPkg::memWord  dataWord,
    output logic                 resultValid,
    output memPkg::memWord       result
);

    memPkg::memOp   op;
    memPkg::memWord extended;

    // request is held for the whole time the unit is busy
    always_comb begin
        dataReq.valid   = busy;
        dataReq.isStore = op.isStore;
        dataReq.size    = op.size;
        dataReq.addr    = op.addr;
        dataReq.wdata   = op.wdata;
    end

    always_comb begin
        case (op.size)
            memPkg::sizeByte: begin
                extended = {{24{op.isSigned & dataWord[7]}}, dataWord[7:0]};
            end
            memPkg::sizeHalf: begin
                extended = {{16{op.isSigned & dataWord[15]}}, dataWord[15:0]};
            end
            default: begin
                extended = dataWord;
            end
        endcase
        // stores report zero
        if (op.isStore) begin
            extended = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= busy && dataDone;
            if (!busy && lsuStart) begin
                busy <= 1'b1;
            end else if (dataDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && lsuStart) begin
            op <= lsuOp;
        end
        if (dataDone) begin
            result <= extended;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  rdy,
    input  wire                  ioFull,
    input  wire                  fetchEnable,
    input  wire                  jumpValid,
    input  wire memPkg::memAddr  jumpTarget,
    output logic                 instValid,
    output memPkg::memWord       inst,
    output memPkg::memAddr       instPc,
    input  wire                  lsuStart,
    input  wire memPkg::memOp    lsuOp,
    output logic                 lsuBusy,
    output logic                 resultValid,
    output memPkg::memWord       result,
    output memPkg::portOwner     owner
);

    logic                           fetchReq;
    memPkg::memAddr                 fetchAddr;
    logic                           fetchDone;
    memPkg::memWord                 fetchWord;
    memPkg::dataReq                 lsuReq;
    logic                           dataDone;
    memPkg::memWord                 dataWord;
    logic [memPkg::ramAddrBits-1:0] ramAddr;
    logic                           ramWe;
    memPkg::memByte                 ramWdata;
    memPkg::memByte                 ramRdata;

    byteRam uRam (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    memCtrl uCtrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchWord (fetchWord),
        .dataReq   (lsuReq),
        .dataDone  (dataDone),
        .dataWord  (dataWord),
        .owner     (owner),
        .ramAddr   (ramAddr),
        .ramWe     (ramWe),
        .ramWdata  (ramWdata),
        .ramRdata  (ramRdata)
    );

    instFetch uFetch (
        .clk         (clk),
        .rst         (rst),
        .fetchEnable (fetchEnable),
        .jumpValid   (jumpValid),
        .jumpTarget  (jumpTarget),
        .fetchReq    (fetchReq),
        .fetchAddr   (fetchAddr),
        .fetchDone   (fetchDone),
        .fetchWord   (fetchWord),
        .instValid   (instValid),
        .inst        (inst),
        .instPc      (instPc)
    );

    loadStoreUnit uLsu (
        .clk         (clk),
        .rst         (rst),
        .lsuStart    (lsuStart),
        .lsuOp       (lsuOp),
        .busy        (lsuBusy),
        .dataReq     (lsuReq),
        .dataDone    (dataDone),
        .dataWord    (dataWord),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

`default_nettype wire

// ==== verification/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    localparam int holdCycles = 5;
    // an op may wait behind one fetch
    localparam int opCount    = 74;
    localparam int opWorst    = 14;
    localparam int fetchCount = 15;
    localparam int fetchWorst = 8;
    localparam int cycleLimit =
        2 * (opCount * opWorst + fetchCount * fetchWorst + 2 * holdCycles + 3);

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              ioFull;
    logic              fetchEnable;
    logic              jumpValid;
    memPkg::memAddr    jumpTarget;
    logic              instValid;
    memPkg::memWord    inst;
    memPkg::memAddr    instPc;
    logic              lsuStart;
    memPkg::memOp      lsuOp;
    logic              lsuBusy;
    logic              resultValid;
    memPkg::memWord    result;
    memPkg::portOwner  owner;

    memPkg::memByte    model [memPkg::ramBytes];
    int                cycleCount = 0;

    memSubsystem u_dut (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioFull      (ioFull),
        .fetchEnable (fetchEnable),
        .jumpValid   (jumpValid),
        .jumpTarget  (jumpTarget),
        .instValid   (instValid),
        .inst        (inst),
        .instPc      (instPc),
        .lsuStart    (lsuStart),
        .lsuOp       (lsuOp),
        .lsuBusy     (lsuBusy),
        .resultValid (resultValid),
        .result      (result),
        .owner       (owner)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            reportFailure($sformatf("timeout: tests still running after %0d cycles", cycleLimit));
        end
    end

    task automatic checkWord(input string name, input memPkg::memWord exp,
                             input memPkg::memWord act);
        if (act !== exp) begin
            reportFailure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic checkAddr(input string name, input memPkg::memAddr exp,
                             input memPkg::memAddr act);
        if (act !== exp) begin
            reportFailure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic checkOwner(input string name, input memPkg::portOwner exp,
                              input memPkg::portOwner act);
        if (act !== exp) begin
            reportFailure($sformatf("ERR %0t %s expected %s actual %s",
                                    $time, name, exp.name(), act.name()));
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            reportFailure($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    function automatic int bytesOf(input memPkg::accessSize size);
        case (size)
            memPkg::sizeByte: return 1;
            memPkg::sizeHalf: return 2;
            default:          return 4;
        endcase
    endfunction

    // only the low address bits reach the RAM
    function automatic logic [memPkg::ramAddrBits-1:0] ramIndex(input memPkg::memAddr a);
        return a[memPkg::ramAddrBits-1:0];
    endfunction

    function automatic memPkg::memWord expectLoad(input memPkg::memOp op);
        memPkg::memWord raw;
        int n;
        raw = '0;
        n = bytesOf(op.size);
        for (int k = 0; k < n; k++) begin
            raw[8 * k +: 8] = model[ramIndex(op.addr + k)];
        end
        if (op.isSigned && n == 1) begin
            raw = {{24{raw[7]}}, raw[7:0]};
        end else if (op.isSigned && n == 2) begin
            raw = {{16{raw[15]}}, raw[15:0]};
        end
        return raw;
    endfunction

    function automatic void writeModel(input memPkg::memOp op);
        for (int k = 0; k < bytesOf(op.size); k++) begin
            model[ramIndex(op.addr + k)] = op.wdata[8 * k +: 8];
        end
    endfunction

    function automatic memPkg::memOp makeOp(input logic st, input logic sg,
                                            input memPkg::accessSize sz,
                                            input memPkg::memAddr a, input memPkg::memWord d);
        memPkg::memOp op;
        op.isStore  = st;
        op.isSigned = sg;
        op.size     = sz;
        op.addr     = a;
        op.wdata    = d;
        return op;
    endfunction

    task automatic startOp(input memPkg::memOp op);
        @(posedge clk);
        lsuOp    <= op;
        lsuStart <= 1'b1;
        @(posedge clk);
        lsuStart <= 1'b0;
    endtask

    // lat counts the start cycle as the first
    task automatic waitResult(output memPkg::memWord res, output int lat);
        lat = 1;
        do begin
            @(negedge clk);
            lat++;
        end while (!resultValid);
        checkBit("lsuBusy", 1'b0, lsuBusy);
        res = result;
    endtask

    task automatic checkedOp(input memPkg::memOp op, input logic timeIt);
        memPkg::memWord got;
        memPkg::memWord want;
        int lat;
        want = op.isStore ? '0 : expectLoad(op);
        startOp(op);
        waitResult(got, lat);
        checkWord("result", want, got);
        if (op.isStore) begin
            writeModel(op);
        end else if (timeIt && lat != bytesOf(op.size) + 3) begin
            reportFailure($sformatf("ERR %0t load latency expected %0d actual %0d",
                                    $time, bytesOf(op.size) + 3, lat));
        end
    endtask

    task automatic jumpTo(input memPkg::memAddr target, input logic enable);
        @(posedge clk);
        jumpValid   <= 1'b1;
        jumpTarget  <= target;
        fetchEnable <= enable;
        @(posedge clk);
        jumpValid <= 1'b0;
    endtask

    task automatic waitOwner(input memPkg::portOwner who);
        do begin
            @(negedge clk);
        end while (owner != who);
    endtask

    // fetch is switched off early enough that exactly count words arrive
    task automatic collectInsts(input memPkg::memAddr base, input int count);
        memPkg::memAddr pcWant;
        int got;
        pcWant = base;
        got = 0;
        while (got < count) begin
            @(negedge clk);
            if (instValid) begin
                checkAddr("instPc", pcWant, instPc);
                checkWord("inst", expectLoad(makeOp(1'b0, 1'b0, memPkg::sizeWord, pcWant, '0)),
                          inst);
                pcWant = pcWant + 32'd4;
                got++;
                if (got == count - 1) begin
                    @(posedge clk);
                    fetchEnable <= 1'b0;
                end
            end
        end
    endtask

    task automatic holdPort(input logic useIoFull);
        @(posedge clk);
        if (useIoFull) begin
            ioFull <= 1'b1;
        end else begin
            rdy <= 1'b0;
        end
        repeat (holdCycles) begin
            @(negedge clk);
            checkBit("ramWe", 1'b0, u_dut.ramWe);
            checkBit("resultValid", 1'b0, resultValid);
            checkOwner("owner", memPkg::ownerData, owner);
        end
        @(posedge clk);
        rdy    <= 1'b1;
        ioFull <= 1'b0;
    endtask

    task automatic resetState();
        @(negedge clk);
        checkBit("instValid", 1'b0, instValid);
        checkBit("resultValid", 1'b0, resultValid);
        checkBit("lsuBusy", 1'b0, lsuBusy);
        checkOwner("owner", memPkg::ownerNone, owner);
    endtask

    task automatic storeLoadWord();
        logic sg;
        checkedOp(makeOp(1'b1, 1'b0, memPkg::sizeWord, 32'h100, 32'hA57F_80C3), 1'b0);
        for (int s = 0; s < 2; s++) begin
            sg = (s == 1);
            checkedOp(makeOp(1'b0, sg, memPkg::sizeWord, 32'h100, '0), 1'b0);
            for (int h = 0; h < 2; h++) begin
                checkedOp(makeOp(1'b0, sg, memPkg::sizeHalf, 32'h100 + 2 * h, '0), 1'b0);
            end
            for (int b = 0; b < 4; b++) begin
                checkedOp(makeOp(1'b0, sg, memPkg::sizeByte, 32'h100 + b, '0), 1'b0);
            end
        end
    endtask

    task automatic randomOps();
        memPkg::memOp op;
        logic [1:0] sizeSel;
        // fill the window first so every load reads known bytes
        for (int i = 0; i < 8; i++) begin
            checkedOp(makeOp(1'b1, 1'b0, memPkg::sizeWord, 32'h200 + 4 * i, $urandom), 1'b0);
        end
        for (int i = 0; i < 40; i++) begin
            sizeSel = 2'($urandom % 3);
            op = makeOp(1'($urandom), 1'($urandom), memPkg::accessSize'(sizeSel),
                        32'h200 + ($urandom % 29), $urandom);
            checkedOp(op, 1'b1);
        end
    endtask

    task automatic fetchStream();
        for (int i = 0; i < 6; i++) begin
            checkedOp(makeOp(1'b1, 1'b0, memPkg::sizeWord, 32'h40 + 4 * i, $urandom), 1'b0);
        end
        jumpTo(32'h40, 1'b1);
        collectInsts(32'h40, 6);
    endtask

    task automatic jumpInFlight();
        checkedOp(makeOp(1'b1, 1'b0, memPkg::sizeWord, 32'h80, $urandom), 1'b0);
        checkedOp(makeOp(1'b1, 1'b0, memPkg::sizeWord, 32'h84, $urandom), 1'b0);
        jumpTo(32'h40, 1'b1);
        waitOwner(memPkg::ownerFetch);
        jumpTo(32'h80, 1'b1);
        collectInsts(32'h80, 2);
    endtask

    task automatic overlapAndHold();
        memPkg::memOp   ldOp;
        memPkg::memOp   stOp;
        memPkg::memWord got;
        int             lat;
        logic           sawInst;
        ldOp = makeOp(1'b0, 1'b1, memPkg::sizeHalf, 32'h206, '0);
        stOp = makeOp(1'b1, 1'b0, memPkg::sizeWord, 32'h210, $urandom);
        waitOwner(memPkg::ownerFetch);
        startOp(ldOp);
        // fetch keeps the port until its word is out
        sawInst = 1'b0;
        while (!sawInst) begin
            @(negedge clk);
            if (instValid) begin
                sawInst = 1'b1;
            end else begin
                checkOwner("owner", memPkg::ownerFetch, owner);
            end
        end
        @(negedge clk);
        checkOwner("owner", memPkg::ownerData, owner);
        waitResult(got, lat);
        checkWord("result", expectLoad(ldOp), got);
        startOp(stOp);
        waitOwner(memPkg::ownerData);
        holdPort(1'b0);
        waitResult(got, lat);
        checkWord("result", '0, got);
        writeModel(stOp);
        ldOp = makeOp(1'b0, 1'b0, memPkg::sizeWord, 32'h210, '0);
        startOp(ldOp);
        waitOwner(memPkg::ownerData);
        holdPort(1'b1);
        waitResult(got, lat);
        checkWord("result", expectLoad(ldOp), got);
    endtask

    initial begin
        void'($urandom(68));
        rst         <= 1'b1;
        rdy         <= 1'b1;
        ioFull      <= 1'b0;
        fetchEnable <= 1'b0;
        jumpValid   <= 1'b0;
        jumpTarget  <= '0;
        lsuStart    <= 1'b0;
        lsuOp       <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        resetState();
        storeLoadWord();
        randomOps();
        fetchStream();
        jumpInFlight();
        jumpTo(32'h40, 1'b1);
        fork
            collectInsts(32'h40, 6);
            overlapAndHold();
        join

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/memPkg.sv
hdl/byteRam.sv
hdl/memCtrl.sv
hdl/instFetch.sv
hdl/loadStoreUnit.sv
hdl/memSubsystem.sv
verification/memSubsystemTb.sv

// ==== Makefile ====
TOP := memSubsystemTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
